// File: compile.f
+incdir+src
src/lsu_pkg.sv
src/lsu_ctrl_if.sv
src/lsu_store_lanes.sv
src/lsu_load_align.sv
src/lsu_fsm.sv
src/lsu_top.sv
verification/lsu_properties.sv
verification/lsu_tb.sv

// File: Makefile
VERILATOR := verilator
FLAGS     := --timing --assert
TOP       := lsu_tb
FILELIST  := compile.f
OBJ       := obj_dir
LOG       := sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ)
	-./$(OBJ)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then exit 1; fi
	@grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(OBJ) $(LOG)

// File: verification/lsu_tb.sv
// directed testbench for the load/store unit
// a byte memory model serves the data bus
// the test tasks play the execute stage

`timescale 1ns/1ps

module lsu_tb;

  localparam int N_ACCESSES  = 100;  // rough count of all accesses below
  localparam int ACC_TIMEOUT = 60;   // cycles per access before giving up
  localparam int SETTLE      = 25;   // quarter period after the falling edge
  localparam int unsigned SEED = 22;

  logic               clk_i = 1'b0;
  logic               rst_ni;
  logic               data_req_o, data_gnt_i, data_rvalid_i, data_err_i;
  logic               data_we_o;
  lsu_pkg::addr_t     data_addr_o;
  lsu_pkg::be_t       data_be_o;
  lsu_pkg::data_t     data_wdata_o, data_rdata_i;
  logic               req_i, we_i, sign_ext_i;
  lsu_pkg::lsu_size_e size_i;
  lsu_pkg::data_t     wdata_i, rdata_o;
  lsu_pkg::addr_t     adder_result_i, addr_last_o;
  logic               addr_incr_req_o, data_valid_o, load_err_o, store_err_o, busy_o;

  logic [7:0]  mem [256];      // bus side memory
  logic [7:0]  ref_mem [256];  // expected contents
  logic [31:0] log_addr [$];   // granted requests of the current access
  logic [3:0]  log_be [$];
  logic        log_we [$];
  logic [31:0] log_wd [$];
  logic [31:0] rsp_data [$];   // responses waiting for rvalid
  logic        rsp_err [$];
  bit          rand_en;        // random grant and rvalid delays
  bit          err_en;         // error injection on err_word
  logic [31:0] err_word;

  lsu_top DUT (.*);

  always #50 clk_i = ~clk_i;

  ////////////////////////////////////////
  // bus slave
  ////////////////////////////////////////

  task automatic take_request();
    logic       bad;
    logic [7:0] base;
    logic [31:0] rd;
    bad  = err_en && (data_addr_o == err_word);
    base = data_addr_o[7:0];
    for (int l = 0; l < 4; l++) begin
      rd[8*l +: 8] = mem[base + l];
      if (data_we_o && data_be_o[l] && !bad) mem[base + l] = data_wdata_o[8*l +: 8];
    end
    log_addr.push_back(data_addr_o);
    log_be.push_back(data_be_o);
    log_we.push_back(data_we_o);
    log_wd.push_back(data_wdata_o);
    rsp_data.push_back(rd);
    rsp_err.push_back(bad);
  endtask

  always @(negedge clk_i) begin
    if (!rst_ni) begin
      data_gnt_i    = 1'b0;
      data_rvalid_i = 1'b0;
      data_err_i    = 1'b0;
    end else begin
      data_gnt_i = rand_en ? ($urandom_range(2) == 0) : 1'b1;
      // a response pushed in the last cycle goes out one cycle after its grant
      if (rsp_data.size() > 0 && (!rand_en || $urandom_range(1) == 0)) begin
        data_rvalid_i = 1'b1;
        data_rdata_i  = rsp_data.pop_front();
        data_err_i    = rsp_err.pop_front();
      end else begin
        data_rvalid_i = 1'b0;
        data_err_i    = 1'b0;
        data_rdata_i  = '0;
      end
    end
    #(SETTLE);
    // request and grant now hold until the rising edge that accepts them
    if (rst_ni && data_req_o && data_gnt_i) take_request();
  end

  ////////////////////////////////////////
  // checking
  ////////////////////////////////////////

  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("TESTBENCH FAILED");
    $fatal(1);
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAILED %s: got 0x%h expected 0x%h", name, got, exp);
      fail_run("value mismatch");
    end
  endtask

  // runs one access as the execute stage and checks it against the memory model
  task automatic run_access(input bit we, input logic [1:0] sz, input bit sext,
                            input logic [31:0] addr, input logic [31:0] wd);
    int          n, off, parts, cyc, k;
    bit          split, first_bad, exp_err, done;
    logic [31:0] word, exp_rd, exp_last, exp_wd, got_rd, got_last;
    logic [3:0]  exp_be;
    logic        got_le, got_se;
    n         = (sz == 2'b00) ? 4 : (sz == 2'b01) ? 2 : 1;
    off       = addr[1:0];
    split     = (off + n) > 4;
    parts     = split ? 2 : 1;
    word      = addr & ~32'h3;
    first_bad = err_en && (word == err_word);
    exp_err   = first_bad || (err_en && split && (word + 4 == err_word));
    exp_last  = (split && !first_bad) ? addr + 4 : addr;
    exp_rd    = '0;
    for (k = 0; k < n; k++) exp_rd[8*k +: 8] = ref_mem[8'(addr + k)];
    if (sext && n < 4 && exp_rd[8*n-1]) exp_rd = exp_rd | (32'hffff_ffff << (8*n));
    log_addr.delete();
    log_be.delete();
    log_we.delete();
    log_wd.delete();

    @(negedge clk_i);
    req_i          = 1'b1;
    we_i           = we;
    size_i         = lsu_pkg::lsu_size_e'(sz);
    sign_ext_i     = sext;
    wdata_i        = wd;
    adder_result_i = addr;
    cyc  = 0;
    done = 0;
    while (!done) begin
      #(SETTLE);  // outputs hold from here until the rising edge
      if (data_valid_o) begin
        got_rd   = rdata_o;
        got_le   = load_err_o;
        got_se   = store_err_o;
        got_last = addr_last_o;
        done     = 1;
      end else begin
        @(negedge clk_i);
        adder_result_i = addr_incr_req_o ? addr_last_o + 4 : addr;  // next word on request
        cyc++;
        if (cyc > ACC_TIMEOUT) fail_run("access never completed with data_valid_o");
      end
    end
    @(negedge clk_i);
    req_i = 1'b0;

    check("request count", log_addr.size(), parts);
    for (int p = 0; p < parts; p++) begin
      for (int l = 0; l < 4; l++) begin
        k            = 4*p + l - off;  // byte of the access in this lane
        exp_be[l]    = (k >= 0) && (k < n);
        exp_wd[8*l +: 8] = wd[8*((l - off) & 3) +: 8];
      end
      check("data_addr_o", log_addr[p], word + 4*p);
      check("data_we_o", log_we[p], we);
      check("data_be_o", log_be[p], exp_be);
      if (we) check("data_wdata_o", log_wd[p], exp_wd);
    end
    check("load_err_o", got_le, exp_err && !we);
    check("store_err_o", got_se, exp_err && we);
    check("addr_last_o", got_last, exp_last);
    if (!we && !exp_err) check("rdata_o", got_rd, exp_rd);
    if (we) begin
      for (k = 0; k < n; k++) begin
        if (!(err_en && (((addr + k) & ~32'h3) == err_word))) begin
          ref_mem[8'(addr + k)] = wd[8*k +: 8];
        end
      end
    end
  endtask

  ////////////////////////////////////////
  // tests
  ////////////////////////////////////////

  task automatic test_reset();
    check("data_req_o", data_req_o, 0);
    check("data_valid_o", data_valid_o, 0);
    check("addr_incr_req_o", addr_incr_req_o, 0);
    check("load_err_o", load_err_o, 0);
    check("store_err_o", store_err_o, 0);
    check("busy_o", busy_o, 0);
  endtask

  task automatic test_aligned();
    run_access(1, 2'b00, 0, 32'h10, 32'h8badf00d);
    run_access(1, 2'b01, 0, 32'h20, 32'h0000c3a5);
    run_access(1, 2'b01, 0, 32'h22, 32'h00007e81);
    for (int o = 0; o < 4; o++) run_access(1, 2'b10, 0, 32'h30 + o, 32'h7c + 8'(o * 3));
    for (int s = 0; s < 2; s++) begin
      run_access(0, 2'b00, s, 32'h10, 0);
      run_access(0, 2'b01, s, 32'h20, 0);
      run_access(0, 2'b01, s, 32'h22, 0);
      for (int o = 0; o < 4; o++) run_access(0, 2'b10, s, 32'h30 + o, 0);
    end
  endtask

  task automatic test_misaligned();
    for (int o = 1; o < 4; o++) begin
      run_access(1, 2'b00, 0, 32'h40 + 8*o + o, 32'h1234_5678 ^ o);
      run_access(0, 2'b00, 0, 32'h40 + 8*o + o, 0);
    end
  endtask

  task automatic test_half_split();
    run_access(1, 2'b01, 0, 32'h6b, 32'h0000_9abc);  // crosses into 0x6c
    for (int o = 0; o < 4; o++) begin
      for (int s = 0; s < 2; s++) begin
        run_access(0, 2'b01, s, 32'h60 + o, 0);
        run_access(0, 2'b10, s, 32'h64 + o, 0);
      end
    end
  endtask

  task automatic test_random();
    rand_en = 1;
    repeat (40) begin
      run_access($urandom_range(1), 2'($urandom_range(3)), $urandom_range(1),
                 32'h80 + $urandom_range(8'h77), $urandom);
    end
    rand_en = 0;
  endtask

  task automatic test_errors();
    err_en   = 1;
    err_word = 32'ha0;  // first part fails
    run_access(0, 2'b00, 0, 32'ha1, 0);
    run_access(1, 2'b00, 0, 32'ha2, 32'h55aa_33cc);
    err_word = 32'ha4;  // second part fails
    run_access(0, 2'b00, 0, 32'ha3, 0);
    run_access(1, 2'b01, 0, 32'ha3, 32'h0000_4411);
    err_word = 32'hb0;  // single aligned part
    run_access(0, 2'b10, 1, 32'hb2, 0);
    err_en = 0;
  endtask

  // watchdog sized from the access count
  initial begin
    #(N_ACCESSES * ACC_TIMEOUT * 100);
    fail_run("watchdog expired, run did not finish in time");
  end

  initial begin
    void'($urandom(SEED));
    for (int i = 0; i < 256; i++) begin
      mem[i]     = 8'(i * 37 + 17);  // distinct per address
      ref_mem[i] = 8'(i * 37 + 17);
    end
    rand_en        = 0;
    err_en         = 0;
    err_word       = '0;
    rst_ni         = 1'b0;
    req_i          = 1'b0;
    we_i           = 1'b0;
    size_i         = lsu_pkg::SIZE_WORD;
    sign_ext_i     = 1'b0;
    wdata_i        = '0;
    adder_result_i = '0;
    data_gnt_i     = 1'b0;
    data_rvalid_i  = 1'b0;
    data_err_i     = 1'b0;
    data_rdata_i   = '0;
    repeat (3) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    test_reset();
    test_aligned();
    test_misaligned();
    test_half_split();
    test_random();
    test_errors();
    repeat (2) @(negedge clk_i);
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

// File: verification/lsu_properties.sv
// bus protocol checks for the load/store unit
// bound to lsu_top, sampled on the rising clock edge

`timescale 1ns/1ps

`include "lsu_params.svh"

module lsu_properties (
  input logic                   clk_i,
  input logic                   rst_ni,
  input logic                   data_req_o,
  input logic                   data_gnt_i,
  input logic                   data_rvalid_i,
  input logic                   data_err_i,
  input logic [`LSU_ADDR_W-1:0] data_addr_o,
  input logic [`LSU_BE_W-1:0]   data_be_o,
  input logic                   data_valid_o
);

  // every part of an access writes or reads at least one byte lane
  a_req_lanes: assert property (@(posedge clk_i) disable iff (!rst_ni)
    data_req_o |-> (data_be_o != '0))
    else $error("request without any byte enable");

  // an ungranted request holds its address
  a_req_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (data_req_o && !data_gnt_i) |=> (data_req_o && $stable(data_addr_o)))
    else $error("request dropped or address changed before grant");

  a_err_with_rvalid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    data_err_i |-> data_rvalid_i)
    else $error("bus error without rvalid");

  a_valid_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    data_valid_o |=> !data_valid_o)
    else $error("data_valid_o longer than one cycle");

endmodule

bind lsu_top lsu_properties u_props (.*);

// File: src/lsu_top.sv
// load/store unit top level
// connects the execute stage to a word-wide req/gnt/rvalid data bus,
// splitting misaligned accesses into two word requests

`timescale 1ns/1ps

`include "lsu_params.svh"

module lsu_top (
  input  logic               clk_i,
  input  logic               rst_ni,

  // data bus
  output logic               data_req_o,
  input  logic               data_gnt_i,
  input  logic               data_rvalid_i,
  input  logic               data_err_i,
  output lsu_pkg::addr_t     data_addr_o,
  output logic               data_we_o,
  output lsu_pkg::be_t       data_be_o,
  output lsu_pkg::data_t     data_wdata_o,
  input  lsu_pkg::data_t     data_rdata_i,

  // execute stage
  input  logic               req_i,
  input  logic               we_i,
  input  lsu_pkg::lsu_size_e size_i,
  input  logic               sign_ext_i,
  input  lsu_pkg::data_t     wdata_i,
  input  lsu_pkg::addr_t     adder_result_i,  // byte address of this part
  output lsu_pkg::data_t     rdata_o,
  output logic               addr_incr_req_o,
  output lsu_pkg::addr_t     addr_last_o,
  output logic               data_valid_o,
  output logic               load_err_o,
  output logic               store_err_o,
  output logic               busy_o
);

  logic [1:0] offset;  // byte offset within the word

  lsu_ctrl_if ctrl_if ();

  assign offset      = adder_result_i[1:0];
  assign data_addr_o = {adder_result_i[`LSU_ADDR_W-1:2], 2'b00};  // bus is word aligned
  assign data_we_o   = we_i;

  lsu_store_lanes u_store_lanes (
    .size_i   (size_i),
    .offset_i (offset),
    .wdata_i  (wdata_i),
    .be_o     (data_be_o),
    .wdata_o  (data_wdata_o),
    .ctrl     (ctrl_if.lanes_mp)
  );

  lsu_load_align u_load_align (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .rdata_i    (data_rdata_i),
    .offset_i   (offset),
    .size_i     (size_i),
    .sign_ext_i (sign_ext_i),
    .rdata_o    (rdata_o),
    .ctrl       (ctrl_if.load_mp)
  );

  lsu_fsm u_fsm (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .req_i           (req_i),
    .we_i            (we_i),
    .adder_result_i  (adder_result_i),
    .data_gnt_i      (data_gnt_i),
    .data_rvalid_i   (data_rvalid_i),
    .data_err_i      (data_err_i),
    .data_req_o      (data_req_o),
    .addr_incr_req_o (addr_incr_req_o),
    .addr_last_o     (addr_last_o),
    .data_valid_o    (data_valid_o),
    .load_err_o      (load_err_o),
    .store_err_o     (store_err_o),
    .busy_o          (busy_o),
    .ctrl            (ctrl_if.fsm_mp)
  );

endmodule

// File: src/lsu_fsm.sv
// bus handshake control of the load/store unit
// drives req/gnt/rvalid for one or two parts per access, asks execute for
// the next word address on splits, tracks errors and the last good address

`timescale 1ns/1ps

module lsu_fsm (
  input  logic           clk_i,
  input  logic           rst_ni,
  input  logic           req_i,            // access request from execute
  input  logic           we_i,             // store when high
  input  lsu_pkg::addr_t adder_result_i,   // byte address from the ALU
  input  logic           data_gnt_i,
  input  logic           data_rvalid_i,
  input  logic           data_err_i,
  output logic           data_req_o,
  output logic           addr_incr_req_o,  // execute must supply addr_last + 4
  output lsu_pkg::addr_t addr_last_o,      // last granted address, for traps
  output logic           data_valid_o,     // one cycle, access complete
  output logic           load_err_o,
  output logic           store_err_o,
  output logic           busy_o,
  lsu_ctrl_if.fsm_mp     ctrl
);

  lsu_pkg::lsu_state_e state_q, state_d;

  logic           second_part_q, second_part_d;  // split access past first grant
  logic           err_q, err_d;                  // error of the first part
  logic           we_q;                          // write flag of the access
  lsu_pkg::addr_t addr_last_q;

  logic           addr_update;
  logic           ctrl_update;
  logic           rdata_update;
  logic           err_done;                      // error seen at completion

  ////////////////////////////////////////
  // next state
  ////////////////////////////////////////

  always_comb begin
    state_d         = state_q;
    second_part_d   = second_part_q;
    err_d           = err_q;
    data_req_o      = 1'b0;
    addr_incr_req_o = 1'b0;
    data_valid_o    = 1'b0;
    addr_update     = 1'b0;
    ctrl_update     = 1'b0;
    rdata_update    = 1'b0;
    err_done        = 1'b0;

    case (state_q)
      lsu_pkg::IDLE: begin
        if (req_i) begin
          data_req_o = 1'b1;
          err_d      = 1'b0;  // fresh access
          if (data_gnt_i) begin
            ctrl_update   = 1'b1;
            addr_update   = 1'b1;
            second_part_d = ctrl.split;
            state_d = ctrl.split ? lsu_pkg::WAIT_RVALID_MIS : lsu_pkg::WAIT_RVALID;
          end else begin
            state_d = ctrl.split ? lsu_pkg::WAIT_GNT_MIS : lsu_pkg::WAIT_GNT;
          end
        end
      end

      lsu_pkg::WAIT_GNT_MIS: begin
        data_req_o = 1'b1;  // hold first part
        if (data_gnt_i) begin
          ctrl_update   = 1'b1;
          addr_update   = 1'b1;
          second_part_d = 1'b1;
          state_d       = lsu_pkg::WAIT_RVALID_MIS;
        end
      end

      lsu_pkg::WAIT_RVALID_MIS: begin
        // second part goes out while the first one is still in flight
        data_req_o      = 1'b1;
        addr_incr_req_o = 1'b1;
        ctrl_update     = data_gnt_i;
        if (data_rvalid_i) begin
          err_d        = data_err_i;
          rdata_update = ~we_q;  // stores have nothing to keep
          // keep the failing first address for the trap handler
          addr_update  = data_gnt_i & ~data_err_i;
          state_d = data_gnt_i ? lsu_pkg::WAIT_RVALID : lsu_pkg::WAIT_GNT;
        end else if (data_gnt_i) begin
          state_d = lsu_pkg::WAIT_RVALID_DONE;  // two parts outstanding
        end
      end

      lsu_pkg::WAIT_GNT: begin
        addr_incr_req_o = second_part_q;  // only the second part uses addr + 4
        data_req_o      = 1'b1;
        if (data_gnt_i) begin
          ctrl_update = 1'b1;
          addr_update = ~err_q;
          state_d     = lsu_pkg::WAIT_RVALID;
        end
      end

      lsu_pkg::WAIT_RVALID: begin
        if (data_rvalid_i) begin
          data_valid_o  = 1'b1;
          err_done      = err_q | data_err_i;  // either part
          second_part_d = 1'b0;
          state_d       = lsu_pkg::IDLE;
        end
      end

      lsu_pkg::WAIT_RVALID_DONE: begin
        // keep addr + 4 on the adder so the second address can still be latched
        addr_incr_req_o = 1'b1;
        if (data_rvalid_i) begin
          err_d        = data_err_i;
          addr_update  = ~data_err_i;  // second grant was deferred until now
          rdata_update = ~we_q;
          state_d      = lsu_pkg::WAIT_RVALID;
        end
      end

      default: begin
        state_d = lsu_pkg::IDLE;
      end
    endcase
  end

  ////////////////////////////////////////
  // registers
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q       <= lsu_pkg::IDLE;
      second_part_q <= 1'b0;
      err_q         <= 1'b0;
    end else begin
      state_q       <= state_d;
      second_part_q <= second_part_d;
      err_q         <= err_d;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      we_q <= 1'b0;
    end else if (ctrl_update) begin
      we_q <= we_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_last_q <= '0;
    end else if (addr_update) begin
      addr_last_q <= adder_result_i;  // full byte address, offset kept
    end
  end

  // outputs
  assign addr_last_o       = addr_last_q;
  assign load_err_o        = err_done & ~we_q;
  assign store_err_o       = err_done &  we_q;
  assign busy_o            = (state_q != lsu_pkg::IDLE);
  assign ctrl.second_part  = second_part_q;
  assign ctrl.ctrl_update  = ctrl_update;
  assign ctrl.rdata_update = rdata_update;

endmodule

// File: src/lsu_load_align.sv
// read data path of the load/store unit
// latches the transaction control on each grant, keeps the upper bytes of
// the first word of a split load and returns the realigned, extended result
// in the cycle of rvalid

`timescale 1ns/1ps

`include "lsu_params.svh"

module lsu_load_align (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  lsu_pkg::data_t     rdata_i,     // word from the bus
  input  logic [1:0]         offset_i,    // byte offset of the request
  input  lsu_pkg::lsu_size_e size_i,      // access size of the request
  input  logic               sign_ext_i,  // sign extend half/byte
  output lsu_pkg::data_t     rdata_o,     // load result to execute
  lsu_ctrl_if.load_mp        ctrl
);

  logic [1:0]                 offset_q;
  lsu_pkg::lsu_size_e         size_q;
  logic                       sign_ext_q;
  logic [`LSU_DATA_W-1:8]     rdata_q;       // bytes 1..3 of the first word

  lsu_pkg::data_t             rdata_joined;  // word built across both parts
  lsu_pkg::data_t             rdata_shift;   // single word shifted down
  lsu_pkg::data_t             rdata_algn;    // value at lsb, not extended
  logic                       use_joined;

  ////////////////////////////////////////
  // transaction registers
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      offset_q   <= 2'b00;
      size_q     <= lsu_pkg::SIZE_WORD;
      sign_ext_q <= 1'b0;
    end else if (ctrl.ctrl_update) begin
      offset_q   <= offset_i;
      size_q     <= size_i;
      sign_ext_q <= sign_ext_i;
    end
  end

  // byte 0 of the first word is never part of a split result
  always_ff @(posedge clk_i) begin
    if (ctrl.rdata_update) begin
      rdata_q <= rdata_i[`LSU_DATA_W-1:8];
    end
  end

  ////////////////////////////////////////
  // realignment
  ////////////////////////////////////////

  // upper bytes of the first word go low, the second word fills in above
  always_comb begin
    case (offset_q)
      2'b01:   rdata_joined = {rdata_i[7:0],  rdata_q[31:8]};
      2'b10:   rdata_joined = {rdata_i[15:0], rdata_q[31:16]};
      2'b11:   rdata_joined = {rdata_i[23:0], rdata_q[31:24]};
      default: rdata_joined = rdata_i;  // aligned word, nothing held
    endcase
  end

  assign rdata_shift = rdata_i >> {offset_q, 3'b000};  // half/byte in one word

  // words always go through the join path, half words only when split
  assign use_joined = (size_q == lsu_pkg::SIZE_WORD) ||
                      ((size_q == lsu_pkg::SIZE_HALF) && (offset_q == 2'b11));

  assign rdata_algn = use_joined ? rdata_joined : rdata_shift;

  ////////////////////////////////////////
  // extension
  ////////////////////////////////////////

  always_comb begin
    case (size_q)
      lsu_pkg::SIZE_WORD: begin
        rdata_o = rdata_algn;
      end
      lsu_pkg::SIZE_HALF: begin
        rdata_o = {{16{sign_ext_q & rdata_algn[15]}}, rdata_algn[15:0]};
      end
      default: begin  // byte, 2'b11 included
        rdata_o = {{24{sign_ext_q & rdata_algn[7]}}, rdata_algn[7:0]};
      end
    endcase
  end

endmodule

// File: src/lsu_store_lanes.sv
// byte lanes for the current bus request
// builds the byte enables of the first or second part, rotates store data
// into its lanes and flags accesses that cross a word boundary

`timescale 1ns/1ps

`include "lsu_params.svh"

module lsu_store_lanes (
  input  lsu_pkg::lsu_size_e size_i,    // access size from execute
  input  logic [1:0]         offset_i,  // byte offset inside the word
  input  lsu_pkg::data_t     wdata_i,   // store data, lsb aligned
  output lsu_pkg::be_t       be_o,      // enables for the current part
  output lsu_pkg::data_t     wdata_o,   // store data in bus lanes
  lsu_ctrl_if.lanes_mp       ctrl
);

  lsu_pkg::be_t               size_mask;  // size bytes starting at lane 0
  logic [2*`LSU_BE_W-1:0]     lane_mask;  // mask over two words
  logic [2*`LSU_DATA_W-1:0]   wdata_dbl;  // doubled word for rotation

  ////////////////////////////////////////
  // byte enables
  ////////////////////////////////////////

  always_comb begin
    case (size_i)
      lsu_pkg::SIZE_WORD: size_mask = 4'b1111;
      lsu_pkg::SIZE_HALF: size_mask = 4'b0011;
      default:            size_mask = 4'b0001;  // byte, also 2'b11
    endcase
  end

  // slide the mask to the offset, whatever falls past byte 3 lands in
  // the upper half and belongs to the next word
  assign lane_mask = {{`LSU_BE_W{1'b0}}, size_mask} << offset_i;

  // first part takes the lanes up to byte 3, second part the rest from byte 0
  assign be_o = ctrl.second_part ? lane_mask[2*`LSU_BE_W-1:`LSU_BE_W]
                                 : lane_mask[`LSU_BE_W-1:0];

  // anything spilled into the upper half needs a second request
  // word at offset 1..3 or half at offset 3, a byte can never get there
  assign ctrl.split = |lane_mask[2*`LSU_BE_W-1:`LSU_BE_W];

  ////////////////////////////////////////
  // write data rotation
  ////////////////////////////////////////

  // rotate left by offset bytes: low bytes go to the upper lanes of the
  // first word, bytes that wrap around sit in the low lanes for part two
  assign wdata_dbl = {wdata_i, wdata_i} << {offset_i, 3'b000};
  assign wdata_o   = wdata_dbl[2*`LSU_DATA_W-1:`LSU_DATA_W];

endmodule

// File: src/lsu_ctrl_if.sv
// per-transaction control strobes between the FSM and the two datapath blocks
// instantiated once in the top level, each block takes its own modport

`timescale 1ns/1ps

interface lsu_ctrl_if;

  logic split;         // request needs two bus parts
  logic second_part;   // split access past its first grant
  logic ctrl_update;   // grant seen, latch offset/size/sign
  logic rdata_update;  // first read word of a split load arrived

  // FSM owns the strobes, reads the split decision
  modport fsm_mp (
    input  split,
    output second_part,
    output ctrl_update,
    output rdata_update
  );

  // store lanes decide the split, pick the part's enables
  modport lanes_mp (
    output split,
    input  second_part
  );

  // load path only listens
  modport load_mp (
    input ctrl_update,
    input rdata_update
  );

endinterface

// File: src/lsu_pkg.sv
// shared types for the load/store unit
// the modules refer to these by scoped name, lsu_pkg::name

`include "lsu_params.svh"

package lsu_pkg;

  typedef logic [`LSU_ADDR_W-1:0] addr_t;  // byte address
  typedef logic [`LSU_DATA_W-1:0] data_t;  // one bus word
  typedef logic [`LSU_BE_W-1:0]   be_t;    // one bit per byte lane

  // access size from the execute stage, 2'b11 is handled as a byte
  typedef enum logic [1:0] {
    SIZE_WORD = 2'b00,
    SIZE_HALF = 2'b01,
    SIZE_BYTE = 2'b10
  } lsu_size_e;

  // bus handshake states
  typedef enum logic [2:0] {
    IDLE,              // no access, waits for req_i
    WAIT_GNT_MIS,      // first part of a split access not yet granted
    WAIT_RVALID_MIS,   // first part granted, second part requested
    WAIT_GNT,          // single or second part waits for grant
    WAIT_RVALID,       // last part granted, waits for its rvalid
    WAIT_RVALID_DONE   // both parts granted, first rvalid still open
  } lsu_state_e;

endpackage

// File: src/lsu_params.svh
// width macros for the load/store unit
// include in any file that sizes a bus, data or byte-enable vector

`ifndef LSU_PARAMS_SVH
`define LSU_PARAMS_SVH

// address bus, byte addressed
`define LSU_ADDR_W 32

// data bus, one word per beat
`define LSU_DATA_W 32

// one enable per data byte
`define LSU_BE_W 4

// bytes per word, used for the split and lane math
`define LSU_BYTES (`LSU_DATA_W / 8)

`endif
